//--- hw/softcore_pkg.sv
`default_nettype none

package softcore_pkg;

  localparam int addr_w   = 40;
  localparam int data_w   = 64;
  localparam int src_id_w = 2;

  typedef enum logic [0:0] {
    read  = 1'b0,
    write = 1'b1
  } mem_op_e;

  // Shared by commands and responses
  typedef struct packed {
    mem_op_e             op;
    logic [src_id_w-1:0] src_id;
    logic [addr_w-1:0]   addr;
    logic [data_w-1:0]   data;
  } mem_msg_t;

  // Local memory map
  localparam logic [addr_w-1:0] dram_base = 40'h80_0000_0000;
  localparam int dev_lsb = 20;
  localparam int dev_w   = 4;

  localparam logic [dev_w-1:0] host_dev  = 4'd0;
  localparam logic [dev_w-1:0] clint_dev = 4'd1;
  localparam logic [dev_w-1:0] cfg_dev   = 4'd2;
  localparam logic [dev_w-1:0] cache_dev = 4'd3;

  // Offsets in the low 16 address bits
  localparam logic [15:0] clint_msip_offset     = 16'h0000;
  localparam logic [15:0] clint_mtimecmp_offset = 16'h4000;
  localparam logic [15:0] clint_mtime_offset    = 16'hBFF8;

  localparam logic [15:0] cfg_freeze_offset   = 16'h0000;
  localparam logic [15:0] cfg_core_id_offset  = 16'h0008;
  localparam logic [15:0] cfg_host_did_offset = 16'h0010;

endpackage

`default_nettype wire

//--- hw/mem_msg_if.sv
`timescale 1ns/10ps
`default_nettype none

interface mem_msg_if;

  // Command half, valid/ready
  softcore_pkg::mem_msg_t cmd_msg;
  logic                   cmd_v;
  logic                   cmd_ready;

  // Response half, valid/yumi
  softcore_pkg::mem_msg_t resp_msg;
  logic                   resp_v;
  logic                   resp_yumi;

  modport fabric (
    output cmd_msg, cmd_v, resp_yumi,
    input  cmd_ready, resp_msg, resp_v
  );

  modport device (
    input  cmd_msg, cmd_v, resp_yumi,
    output cmd_ready, resp_msg, resp_v
  );

endinterface

`default_nettype wire

//--- hw/cmd_two_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module cmd_two_fifo (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  softcore_pkg::mem_msg_t msg_i,
  input  logic                   v_i,
  output logic                   ready_o,
  output softcore_pkg::mem_msg_t msg_o,
  output logic                   v_o,
  input  logic                   yumi_i
);

  softcore_pkg::mem_msg_t mem_q [2];
  logic wr_ptr_q, rd_ptr_q;
  logic full_q, empty_q;
  logic push, pop;

  assign ready_o = ~full_q;
  assign v_o     = ~empty_q;
  assign msg_o   = mem_q[rd_ptr_q];

  assign push = v_i & ~full_q;
  assign pop  = yumi_i & ~empty_q;

  always_ff @(posedge clk_i)
  begin
    if (push)
    begin
      mem_q[wr_ptr_q] <= msg_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      full_q   <= 1'b0;
      empty_q  <= 1'b1;
    end
    else
    begin
      if (push)
      begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop)
      begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      // Occupancy only changes when one side moves alone
      if (push && !pop)
      begin
        empty_q <= 1'b0;
        full_q  <= (~wr_ptr_q == rd_ptr_q);
      end
      else if (pop && !push)
      begin
        full_q  <= 1'b0;
        empty_q <= (~rd_ptr_q == wr_ptr_q);
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/cmd_dispatch_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module cmd_dispatch_fsm #(
  parameter int num_req_p = 3
) (
  input  logic                                   clk_i,
  input  logic                                   arst_n_i,

  input  softcore_pkg::mem_msg_t [num_req_p-1:0] fifo_msg_i,
  input  logic [num_req_p-1:0]                   fifo_v_i,
  output logic [num_req_p-1:0]                   fifo_yumi_o,

  mem_msg_if.fabric                              cfg_bus,
  mem_msg_if.fabric                              clint_bus,

  output softcore_pkg::mem_msg_t                 io_cmd_msg_o,
  output logic                                   io_cmd_v_o,
  input  logic                                   io_cmd_ready_i,

  output softcore_pkg::mem_msg_t                 mem_cmd_msg_o,
  output logic                                   mem_cmd_v_o,
  input  logic                                   mem_cmd_ready_i
);

  typedef enum logic {
    st_idle,
    st_send
  } state_e;

  typedef enum logic [1:0] {
    tgt_mem,
    tgt_io,
    tgt_cfg,
    tgt_clint
  } target_e;

  state_e                         state_q;
  target_e                        tgt_q, tgt_d;
  softcore_pkg::mem_msg_t         msg_q, sel_msg;
  logic [num_req_p-1:0]           grant_oh;
  logic [softcore_pkg::dev_w-1:0] dev_code;
  logic                           issue;
  logic                           tgt_ready;

  // Highest index wins
  always_comb
  begin
    grant_oh = '0;
    sel_msg  = '0;
    for (int i = 0; i < num_req_p; i++)
    begin
      if (fifo_v_i[i])
      begin
        grant_oh    = '0;
        grant_oh[i] = 1'b1;
        sel_msg     = fifo_msg_i[i];
      end
    end
  end

  assign dev_code = sel_msg.addr[softcore_pkg::dev_lsb +: softcore_pkg::dev_w];

  always_comb
  begin
    if (sel_msg.addr >= softcore_pkg::dram_base)
    begin
      tgt_d = tgt_mem;
    end
    else
    begin
      case (dev_code)
        softcore_pkg::cache_dev: tgt_d = tgt_mem;
        softcore_pkg::cfg_dev:   tgt_d = tgt_cfg;
        softcore_pkg::clint_dev: tgt_d = tgt_clint;
        default:                 tgt_d = tgt_io;
      endcase
    end
  end

  assign issue       = (state_q == st_idle) & (|fifo_v_i);
  assign fifo_yumi_o = issue ? grant_oh : '0;

  always_comb
  begin
    case (tgt_q)
      tgt_io:    tgt_ready = io_cmd_ready_i;
      tgt_cfg:   tgt_ready = cfg_bus.cmd_ready;
      tgt_clint: tgt_ready = clint_bus.cmd_ready;
      default:   tgt_ready = mem_cmd_ready_i;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (issue)
    begin
      msg_q <= sel_msg;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_q <= st_idle;
      tgt_q   <= tgt_mem;
    end
    else
    begin
      case (state_q)
        st_idle:
        begin
          if (issue)
          begin
            tgt_q   <= tgt_d;
            state_q <= st_send;
          end
        end
        default:
        begin
          if (tgt_ready)
          begin
            state_q <= st_idle;
          end
        end
      endcase
    end
  end

  assign cfg_bus.cmd_msg   = msg_q;
  assign clint_bus.cmd_msg = msg_q;
  assign io_cmd_msg_o      = msg_q;
  assign mem_cmd_msg_o     = msg_q;

  assign cfg_bus.cmd_v   = (state_q == st_send) & (tgt_q == tgt_cfg);
  assign clint_bus.cmd_v = (state_q == st_send) & (tgt_q == tgt_clint);
  assign io_cmd_v_o      = (state_q == st_send) & (tgt_q == tgt_io);
  assign mem_cmd_v_o     = (state_q == st_send) & (tgt_q == tgt_mem);

endmodule

`default_nettype wire

//--- hw/clint_timer.sv
`timescale 1ns/10ps
`default_nettype none

module clint_timer (
  input  logic      clk_i,
  input  logic      arst_n_i,
  mem_msg_if.device bus,
  output logic      timer_irq_o,
  output logic      software_irq_o
);

  logic [softcore_pkg::data_w-1:0] mtime_q;
  logic [softcore_pkg::data_w-1:0] mtimecmp_q;
  logic                            msip_q;
  logic                            resp_v_q;
  softcore_pkg::mem_msg_t          resp_msg_q, resp_d;
  logic [softcore_pkg::data_w-1:0] rd_data;
  logic [15:0]                     offset;
  logic                            cmd_fire, wr_fire;

  assign cmd_fire = bus.cmd_v & bus.cmd_ready;
  assign wr_fire  = cmd_fire & (bus.cmd_msg.op == softcore_pkg::write);
  assign offset   = bus.cmd_msg.addr[15:0];

  always_comb
  begin
    rd_data = '0;
    case (offset)
      softcore_pkg::clint_msip_offset:     rd_data[0] = msip_q;
      softcore_pkg::clint_mtimecmp_offset: rd_data = mtimecmp_q;
      softcore_pkg::clint_mtime_offset:    rd_data = mtime_q;
      default:                             rd_data = '0;
    endcase
  end

  // Writes answer with zero data
  always_comb
  begin
    resp_d      = bus.cmd_msg;
    resp_d.data = (bus.cmd_msg.op == softcore_pkg::write) ? '0 : rd_data;
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_fire)
    begin
      resp_msg_q <= resp_d;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      msip_q     <= 1'b0;
      resp_v_q   <= 1'b0;
    end
    else
    begin
      mtime_q <= mtime_q + 1'b1;
      if (wr_fire)
      begin
        case (offset)
          softcore_pkg::clint_msip_offset:     msip_q <= bus.cmd_msg.data[0];
          softcore_pkg::clint_mtimecmp_offset: mtimecmp_q <= bus.cmd_msg.data;
          softcore_pkg::clint_mtime_offset:    mtime_q <= bus.cmd_msg.data;
          default:                             msip_q <= msip_q;
        endcase
      end
      if (cmd_fire)
      begin
        resp_v_q <= 1'b1;
      end
      else if (bus.resp_yumi)
      begin
        resp_v_q <= 1'b0;
      end
    end
  end

  assign bus.cmd_ready = ~resp_v_q;
  assign bus.resp_v    = resp_v_q;
  assign bus.resp_msg  = resp_msg_q;

  assign timer_irq_o    = (mtime_q >= mtimecmp_q);
  assign software_irq_o = msip_q;

endmodule

`default_nettype wire

//--- hw/cfg_regs.sv
`timescale 1ns/10ps
`default_nettype none

module cfg_regs (
  input  logic      clk_i,
  input  logic      arst_n_i,
  mem_msg_if.device bus,
  output logic      cfg_freeze_o
);

  logic                            freeze_q;
  logic [7:0]                      core_id_q;
  logic [7:0]                      host_did_q;
  logic                            resp_v_q;
  softcore_pkg::mem_msg_t          resp_msg_q, resp_d;
  logic [softcore_pkg::data_w-1:0] rd_data;
  logic [15:0]                     offset;
  logic                            cmd_fire, wr_fire;

  assign cmd_fire = bus.cmd_v & bus.cmd_ready;
  assign wr_fire  = cmd_fire & (bus.cmd_msg.op == softcore_pkg::write);
  assign offset   = bus.cmd_msg.addr[15:0];

  always_comb
  begin
    rd_data = '0;
    case (offset)
      softcore_pkg::cfg_freeze_offset:   rd_data[0]   = freeze_q;
      softcore_pkg::cfg_core_id_offset:  rd_data[7:0] = core_id_q;
      softcore_pkg::cfg_host_did_offset: rd_data[7:0] = host_did_q;
      default:                           rd_data      = '0;
    endcase
  end

  always_comb
  begin
    resp_d      = bus.cmd_msg;
    resp_d.data = (bus.cmd_msg.op == softcore_pkg::write) ? '0 : rd_data;
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_fire)
    begin
      resp_msg_q <= resp_d;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      // Core starts frozen
      freeze_q   <= 1'b1;
      core_id_q  <= '0;
      host_did_q <= '0;
      resp_v_q   <= 1'b0;
    end
    else
    begin
      if (wr_fire)
      begin
        case (offset)
          softcore_pkg::cfg_freeze_offset:   freeze_q   <= bus.cmd_msg.data[0];
          softcore_pkg::cfg_core_id_offset:  core_id_q  <= bus.cmd_msg.data[7:0];
          softcore_pkg::cfg_host_did_offset: host_did_q <= bus.cmd_msg.data[7:0];
          default:                           freeze_q   <= freeze_q;
        endcase
      end
      if (cmd_fire)
      begin
        resp_v_q <= 1'b1;
      end
      else if (bus.resp_yumi)
      begin
        resp_v_q <= 1'b0;
      end
    end
  end

  assign bus.cmd_ready = ~resp_v_q;
  assign bus.resp_v    = resp_v_q;
  assign bus.resp_msg  = resp_msg_q;
  assign cfg_freeze_o  = freeze_q;

endmodule

`default_nettype wire

//--- hw/resp_router.sv
`timescale 1ns/10ps
`default_nettype none

module resp_router #(
  parameter int num_req_p = 3
) (
  mem_msg_if.fabric                              cfg_bus,
  mem_msg_if.fabric                              clint_bus,

  input  softcore_pkg::mem_msg_t                 io_resp_msg_i,
  input  logic                                   io_resp_v_i,
  output logic                                   io_resp_yumi_o,

  input  softcore_pkg::mem_msg_t                 mem_resp_msg_i,
  input  logic                                   mem_resp_v_i,
  output logic                                   mem_resp_yumi_o,

  output softcore_pkg::mem_msg_t [num_req_p-1:0] req_resp_msg_o,
  output logic [num_req_p-1:0]                   req_resp_v_o,
  input  logic [num_req_p-1:0]                   req_resp_yumi_i
);

  logic [num_req_p-1:0] cfg_match, clint_match, io_match, mem_match;

  // One outstanding command per requester keeps each match one-hot
  for (genvar i = 0; i < num_req_p; i++)
  begin : g_req
    assign cfg_match[i] = cfg_bus.resp_v
                        & (cfg_bus.resp_msg.src_id == softcore_pkg::src_id_w'(i));
    assign clint_match[i] = clint_bus.resp_v
                          & (clint_bus.resp_msg.src_id == softcore_pkg::src_id_w'(i));
    assign io_match[i]  = io_resp_v_i & (io_resp_msg_i.src_id == softcore_pkg::src_id_w'(i));
    assign mem_match[i] = mem_resp_v_i & (mem_resp_msg_i.src_id == softcore_pkg::src_id_w'(i));

    assign req_resp_msg_o[i] = mem_match[i]   ? mem_resp_msg_i     :
                               io_match[i]    ? io_resp_msg_i      :
                               clint_match[i] ? clint_bus.resp_msg :
                                                cfg_bus.resp_msg;
    assign req_resp_v_o[i] = cfg_match[i] | clint_match[i] | io_match[i] | mem_match[i];
  end

  assign cfg_bus.resp_yumi   = |(cfg_match & req_resp_yumi_i);
  assign clint_bus.resp_yumi = |(clint_match & req_resp_yumi_i);
  assign io_resp_yumi_o      = |(io_match & req_resp_yumi_i);
  assign mem_resp_yumi_o     = |(mem_match & req_resp_yumi_i);

endmodule

`default_nettype wire

//--- hw/softcore_uncore.sv
`timescale 1ns/10ps
`default_nettype none

module softcore_uncore #(
  parameter int num_req_p = 3
) (
  input  logic                                   clk_i,
  input  logic                                   arst_n_i,

  // Requesters
  input  softcore_pkg::mem_msg_t [num_req_p-1:0] req_cmd_msg_i,
  input  logic [num_req_p-1:0]                   req_cmd_v_i,
  output logic [num_req_p-1:0]                   req_cmd_ready_o,
  output softcore_pkg::mem_msg_t [num_req_p-1:0] req_resp_msg_o,
  output logic [num_req_p-1:0]                   req_resp_v_o,
  input  logic [num_req_p-1:0]                   req_resp_yumi_i,

  // Outgoing host I/O
  output softcore_pkg::mem_msg_t                 io_cmd_msg_o,
  output logic                                   io_cmd_v_o,
  input  logic                                   io_cmd_ready_i,
  input  softcore_pkg::mem_msg_t                 io_resp_msg_i,
  input  logic                                   io_resp_v_i,
  output logic                                   io_resp_yumi_o,

  // Memory
  output softcore_pkg::mem_msg_t                 mem_cmd_msg_o,
  output logic                                   mem_cmd_v_o,
  input  logic                                   mem_cmd_ready_i,
  input  softcore_pkg::mem_msg_t                 mem_resp_msg_i,
  input  logic                                   mem_resp_v_i,
  output logic                                   mem_resp_yumi_o,

  output logic                                   timer_irq_o,
  output logic                                   software_irq_o,
  output logic                                   cfg_freeze_o
);

  softcore_pkg::mem_msg_t [num_req_p-1:0] fifo_msg;
  logic [num_req_p-1:0]                   fifo_v;
  logic [num_req_p-1:0]                   fifo_yumi;

  mem_msg_if cfg_if ();
  mem_msg_if clint_if ();

  for (genvar i = 0; i < num_req_p; i++)
  begin : g_fifo
    cmd_two_fifo i_fifo (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .msg_i    (req_cmd_msg_i[i]),
      .v_i      (req_cmd_v_i[i]),
      .ready_o  (req_cmd_ready_o[i]),
      .msg_o    (fifo_msg[i]),
      .v_o      (fifo_v[i]),
      .yumi_i   (fifo_yumi[i])
    );
  end

  cmd_dispatch_fsm #(
    .num_req_p (num_req_p)
  ) i_dispatch (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .fifo_msg_i      (fifo_msg),
    .fifo_v_i        (fifo_v),
    .fifo_yumi_o     (fifo_yumi),
    .cfg_bus         (cfg_if.fabric),
    .clint_bus       (clint_if.fabric),
    .io_cmd_msg_o    (io_cmd_msg_o),
    .io_cmd_v_o      (io_cmd_v_o),
    .io_cmd_ready_i  (io_cmd_ready_i),
    .mem_cmd_msg_o   (mem_cmd_msg_o),
    .mem_cmd_v_o     (mem_cmd_v_o),
    .mem_cmd_ready_i (mem_cmd_ready_i)
  );

  cfg_regs i_cfg (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .bus          (cfg_if.device),
    .cfg_freeze_o (cfg_freeze_o)
  );

  clint_timer i_clint (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .bus            (clint_if.device),
    .timer_irq_o    (timer_irq_o),
    .software_irq_o (software_irq_o)
  );

  resp_router #(
    .num_req_p (num_req_p)
  ) i_router (
    .cfg_bus         (cfg_if.fabric),
    .clint_bus       (clint_if.fabric),
    .io_resp_msg_i   (io_resp_msg_i),
    .io_resp_v_i     (io_resp_v_i),
    .io_resp_yumi_o  (io_resp_yumi_o),
    .mem_resp_msg_i  (mem_resp_msg_i),
    .mem_resp_v_i    (mem_resp_v_i),
    .mem_resp_yumi_o (mem_resp_yumi_o),
    .req_resp_msg_o  (req_resp_msg_o),
    .req_resp_v_o    (req_resp_v_o),
    .req_resp_yumi_i (req_resp_yumi_i)
  );

endmodule

`default_nettype wire

//--- testbench/tb_clk_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
  parameter real period_p = 8.0
) (
  output logic clk_o
);

  initial
  begin
    clk_o = 1'b0;
  end

  always #(period_p / 2.0) clk_o = ~clk_o;

endmodule

`default_nettype wire

//--- testbench/softcore_uncore_assert.sv
`timescale 1ns/10ps
`default_nettype none

module softcore_uncore_assert #(
  parameter int num_req_p = 3
) (
  input logic                         clk_i,
  input logic                         arst_n_i,
  input logic [3:0]                   tgt_v_i,
  input logic                         tgt_ready_i,
  input softcore_pkg::mem_msg_t       cmd_msg_i,
  input logic [num_req_p-1:0]         cfg_match_i,
  input logic [num_req_p-1:0]         clint_match_i,
  input logic [num_req_p-1:0]         io_match_i,
  input logic [num_req_p-1:0]         mem_match_i
);

  one_target: assert property (@(posedge clk_i) disable iff (!arst_n_i) $onehot0(tgt_v_i))
    else $error("more than one dispatch target valid");

  // Held command must not change while stalled
  msg_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (|tgt_v_i && !tgt_ready_i) |=> $stable(cmd_msg_i))
    else $error("dispatch message changed while waiting for ready");

  for (genvar i = 0; i < num_req_p; i++)
  begin : g_req
    one_source: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      $onehot0({cfg_match_i[i], clint_match_i[i], io_match_i[i], mem_match_i[i]}))
      else $error("requester %0d matched by several response sources", i);
  end

endmodule

bind softcore_uncore softcore_uncore_assert #(
  .num_req_p (num_req_p)
) i_assert (
  .clk_i         (clk_i),
  .arst_n_i      (arst_n_i),
  .tgt_v_i       ({cfg_if.cmd_v, clint_if.cmd_v, io_cmd_v_o, mem_cmd_v_o}),
  .tgt_ready_i   (i_dispatch.tgt_ready),
  .cmd_msg_i     (io_cmd_msg_o),
  .cfg_match_i   (i_router.cfg_match),
  .clint_match_i (i_router.clint_match),
  .io_match_i    (i_router.io_match),
  .mem_match_i   (i_router.mem_match)
);

`default_nettype wire

//--- testbench/softcore_uncore_tb.sv
`timescale 1ns/10ps
`default_nettype none

// Memory or host space behind a valid/ready command and valid/yumi response port
module target_model (
  input  logic                   clk_i,
  input  logic                   hold_i,
  input  softcore_pkg::mem_msg_t cmd_msg_i,
  input  logic                   cmd_v_i,
  output logic                   cmd_ready_o,
  output softcore_pkg::mem_msg_t resp_msg_o,
  output logic                   resp_v_o,
  input  logic                   resp_yumi_i
);

  logic [63:0]            words [logic [39:0]];
  softcore_pkg::mem_msg_t pend_q [$];
  softcore_pkg::mem_msg_t log_q [$];
  softcore_pkg::mem_msg_t m;
  logic                   busy;
  int                     dly;

  initial
  begin
    cmd_ready_o = 1'b0;
    resp_v_o    = 1'b0;
    resp_msg_o  = '0;
    busy        = 1'b0;
    dly         = -1;
  end

  always
  begin
    @(posedge clk_i);
    if (cmd_v_i && cmd_ready_o)
    begin
      pend_q.push_back(cmd_msg_i);
      log_q.push_back(cmd_msg_i);
    end
    if (resp_v_o && resp_yumi_i)
    begin
      busy = 1'b0;
    end
    @(negedge clk_i);
    cmd_ready_o = !hold_i;
    resp_v_o    = busy;
    if (!busy && pend_q.size() > 0)
    begin
      if (dly < 0)
      begin
        dly = int'($urandom % 4);
      end
      if (dly == 0)
      begin
        m = pend_q.pop_front();
        if (m.op == softcore_pkg::write)
        begin
          words[m.addr] = m.data;
          m.data = '0;
        end
        else
        begin
          m.data = words.exists(m.addr) ? words[m.addr] : 64'h0;
        end
        resp_msg_o = m;
        resp_v_o   = 1'b1;
        busy       = 1'b1;
        dly        = -1;
      end
      else
      begin
        dly--;
      end
    end
  end

endmodule

module softcore_uncore_tb;

  localparam int num_req_p = 3;
  localparam int max_vec   = 64;

  logic clk, arst_n;
  softcore_pkg::mem_msg_t [num_req_p-1:0] req_cmd_msg, req_resp_msg;
  logic [num_req_p-1:0] req_cmd_v, req_cmd_ready, req_resp_v, req_resp_yumi;
  softcore_pkg::mem_msg_t io_cmd_msg, io_resp_msg, mem_cmd_msg, mem_resp_msg;
  logic io_cmd_v, io_cmd_ready, io_resp_v, io_resp_yumi;
  logic mem_cmd_v, mem_cmd_ready, mem_resp_v, mem_resp_yumi;
  logic timer_irq, sw_irq, freeze;
  logic mem_hold;
  logic [63:0] vec [0:7*max_vec-1];
  int nvec;
  int limit_cycles = 0;

  tb_clk_gen #(.period_p (8.0)) i_clk (.clk_o (clk));

  softcore_uncore #(.num_req_p (num_req_p)) i_dut (
    .clk_i (clk), .arst_n_i (arst_n),
    .req_cmd_msg_i (req_cmd_msg), .req_cmd_v_i (req_cmd_v), .req_cmd_ready_o (req_cmd_ready),
    .req_resp_msg_o (req_resp_msg), .req_resp_v_o (req_resp_v),
    .req_resp_yumi_i (req_resp_yumi),
    .io_cmd_msg_o (io_cmd_msg), .io_cmd_v_o (io_cmd_v), .io_cmd_ready_i (io_cmd_ready),
    .io_resp_msg_i (io_resp_msg), .io_resp_v_i (io_resp_v), .io_resp_yumi_o (io_resp_yumi),
    .mem_cmd_msg_o (mem_cmd_msg), .mem_cmd_v_o (mem_cmd_v), .mem_cmd_ready_i (mem_cmd_ready),
    .mem_resp_msg_i (mem_resp_msg), .mem_resp_v_i (mem_resp_v),
    .mem_resp_yumi_o (mem_resp_yumi),
    .timer_irq_o (timer_irq), .software_irq_o (sw_irq), .cfg_freeze_o (freeze)
  );

  target_model i_mem_model (
    .clk_i (clk), .hold_i (mem_hold), .cmd_msg_i (mem_cmd_msg), .cmd_v_i (mem_cmd_v),
    .cmd_ready_o (mem_cmd_ready), .resp_msg_o (mem_resp_msg), .resp_v_o (mem_resp_v),
    .resp_yumi_i (mem_resp_yumi)
  );

  target_model i_io_model (
    .clk_i (clk), .hold_i (1'b0), .cmd_msg_i (io_cmd_msg), .cmd_v_i (io_cmd_v),
    .cmd_ready_o (io_cmd_ready), .resp_msg_o (io_resp_msg), .resp_v_o (io_resp_v),
    .resp_yumi_i (io_resp_yumi)
  );

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp)
    begin
      $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      $display("tests failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // 0 memory, 1 host, 2 local device
  function automatic int target_of(input logic [39:0] addr);
    logic [3:0] dev;
    dev = addr[23:20];
    if (addr >= 40'h80_0000_0000 || dev == 4'd3)
      return 0;
    if (dev == 4'd1 || dev == 4'd2)
      return 2;
    return 1;
  endfunction

  task automatic send_cmd(input int r, input softcore_pkg::mem_msg_t m);
    @(negedge clk);
    req_cmd_msg[r] = m;
    req_cmd_v[r]   = 1'b1;
    do @(posedge clk); while (!req_cmd_ready[r]);
    @(negedge clk);
    req_cmd_v[r] = 1'b0;
  endtask

  task automatic get_resp(input int r, output softcore_pkg::mem_msg_t rsp);
    do @(posedge clk); while (!req_resp_v[r]);
    rsp = req_resp_msg[r];
    check_val("req_resp_v_o (other requesters)", 64'(req_resp_v & ~(3'b001 << r)), 0);
    @(negedge clk);
    req_resp_yumi[r] = 1'b1;
    @(negedge clk);
    req_resp_yumi[r] = 1'b0;
  endtask

  task automatic do_txn(input int r, input logic op, input logic [39:0] addr,
                        input logic [63:0] wdata, output logic [63:0] rdata);
    softcore_pkg::mem_msg_t m, rsp;
    m.op     = softcore_pkg::mem_op_e'(op);
    m.src_id = 2'(r);
    m.addr   = addr;
    m.data   = wdata;
    send_cmd(r, m);
    get_resp(r, rsp);
    check_val("req_resp_msg_o.src_id", 64'(rsp.src_id), 64'(r));
    check_val("req_resp_msg_o.op", 64'(rsp.op), 64'(op));
    check_val("req_resp_msg_o.addr", 64'(rsp.addr), 64'(addr));
    rdata = rsp.data;
  endtask

  task automatic check_log(input string name, input softcore_pkg::mem_msg_t got,
                           input int r, input logic op, input logic [39:0] addr,
                           input logic [63:0] wdata);
    check_val({name, ".src_id"}, 64'(got.src_id), 64'(r));
    check_val({name, ".op"}, 64'(got.op), 64'(op));
    check_val({name, ".addr"}, 64'(got.addr), 64'(addr));
    if (op)
      check_val({name, ".data"}, got.data, wdata);
  endtask

  task automatic run_vector(input int n);
    logic [63:0] kind, rq, op, addr, wdata, exp, flags, rd, t0;
    softcore_pkg::mem_msg_t m, rsp;
    int base;
    kind  = vec[7*n];
    rq    = vec[7*n+1];
    op    = vec[7*n+2];
    addr  = vec[7*n+3];
    wdata = vec[7*n+4];
    exp   = vec[7*n+5];
    flags = vec[7*n+6];
    case (kind)
      0:
      begin
        do_txn(int'(rq), op[0], addr[39:0], wdata, rd);
        check_val("req_resp_msg_o.data", rd, exp);
        if (target_of(addr[39:0]) == 0)
          check_log("mem_cmd_msg_o", i_mem_model.log_q[$], int'(rq), op[0], addr[39:0], wdata);
        else if (target_of(addr[39:0]) == 1)
          check_log("io_cmd_msg_o", i_io_model.log_q[$], int'(rq), op[0], addr[39:0], wdata);
        check_val("{cfg_freeze_o,timer_irq_o,software_irq_o}",
                  64'({freeze, timer_irq, sw_irq}), flags);
      end
      1:
      begin
        do_txn(int'(rq), 1'b0, addr[39:0], 64'h0, t0);
        do_txn(int'(rq), 1'b0, addr[39:0], 64'h0, rd);
        check_val("mtime second read above first", 64'(rd > t0), 1);
      end
      2:
      begin
        base = i_mem_model.log_q.size();
        @(negedge clk);
        for (int i = 0; i < num_req_p; i++)
        begin
          m.op           = softcore_pkg::write;
          m.src_id       = 2'(i);
          m.addr         = addr[39:0] + 40'(8 * i);
          m.data         = wdata + 64'(i);
          req_cmd_msg[i] = m;
        end
        req_cmd_v = '1;
        @(posedge clk);
        check_val("req_cmd_ready_o", 64'(req_cmd_ready), 64'h7);
        @(negedge clk);
        req_cmd_v = '0;
        for (int r = num_req_p - 1; r >= 0; r--)
        begin
          get_resp(r, rsp);
          check_val("req_resp_msg_o.data", rsp.data, 0);
        end
        for (int k = 0; k < num_req_p; k++)
          check_log("mem_cmd_msg_o", i_mem_model.log_q[base+k], num_req_p - 1 - k, 1'b1,
                    addr[39:0] + 40'(8 * (num_req_p - 1 - k)), wdata + 64'(num_req_p - 1 - k));
      end
      default:
      begin
        base = i_mem_model.log_q.size();
        @(negedge clk);
        mem_hold = 1'b1;
        repeat (2) @(negedge clk);
        for (int k = 0; k < 3; k++)
        begin
          m.op     = softcore_pkg::write;
          m.src_id = 2'(rq);
          m.addr   = addr[39:0] + 40'(8 * k);
          m.data   = wdata + 64'(k);
          send_cmd(int'(rq), m);
        end
        @(posedge clk);
        check_val("req_cmd_ready_o[0]", 64'(req_cmd_ready[rq]), 0);
        @(negedge clk);
        mem_hold = 1'b0;
        for (int k = 0; k < 3; k++)
        begin
          get_resp(int'(rq), rsp);
          check_val("req_resp_msg_o.data", rsp.data, 0);
          check_log("mem_cmd_msg_o", i_mem_model.log_q[base+k], int'(rq), 1'b1,
                    addr[39:0] + 40'(8 * k), wdata + 64'(k));
        end
      end
    endcase
  endtask

  initial
  begin
    void'($urandom(38027));
    arst_n        = 1'b0;
    req_cmd_msg   = '0;
    req_cmd_v     = '0;
    req_resp_yumi = '0;
    mem_hold      = 1'b0;
    $readmemh("testbench/uncore_vectors.txt", vec);
    nvec = 0;
    while (nvec < max_vec && vec[7*nvec] != 64'hff)
      nvec++;
    limit_cycles = nvec * 40 + 2000;
    repeat (16) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    @(posedge clk);
    check_val("req_cmd_ready_o after reset", 64'(req_cmd_ready), 64'h7);
    check_val("{cfg_freeze_o,timer_irq_o,software_irq_o} after reset",
              64'({freeze, timer_irq, sw_irq}), 64'h4);
    check_val("req_resp_v_o after reset", 64'(req_resp_v), 64'h0);
    check_val("{io_cmd_v_o,mem_cmd_v_o,io_resp_yumi_o,mem_resp_yumi_o} after reset",
              64'({io_cmd_v, mem_cmd_v, io_resp_yumi, mem_resp_yumi}), 64'h0);
    for (int n = 0; n < nvec; n++)
      run_vector(n);
    $display("all tests passed");
    $finish;
  end

  initial
  begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", limit_cycles);
    $display("tests failed");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

//--- testbench/uncore_vectors.txt
// kind req op addr wdata exp_data exp_flags({freeze,timer_irq,sw_irq})
// kind 0 single command, 1 mtime pair, 2 arbitration, 3 back-pressure, ff end
0 0 1 0000200008 00000000000000a5 0 4
0 0 0 0000200008 0 a5 4
0 0 1 0000200010 3c 0 4
0 0 0 0000200010 0 3c 4
0 0 1 0000200000 0 0 0
0 0 0 0000200000 0 0 0
0 1 1 8000000100 1122334455667788 0 0
0 1 0 8000000100 0 1122334455667788 0
0 2 1 0000300040 cafe 0 0
0 0 0 0000300040 0 cafe 0
0 2 1 0000000080 beef 0 0
0 1 0 0000000080 0 beef 0
0 0 1 0000500000 77 0 0
0 2 0 0000500000 0 77 0
2 0 1 8000000200 a0 0 0
3 0 1 8000000300 b0 0 0
0 0 0 8000000208 0 a1 0
0 1 0 8000000310 0 b2 0
0 0 1 0000100000 1 0 1
0 0 1 0000104000 0 0 3
0 0 1 0000104000 ffffffffffffffff 0 1
1 0 0 000010bff8 0 0 0
ff 0 0 0 0 0 0

//--- flist.f
hw/softcore_pkg.sv
hw/mem_msg_if.sv
hw/cmd_two_fifo.sv
hw/cmd_dispatch_fsm.sv
hw/clint_timer.sv
hw/cfg_regs.sv
hw/resp_router.sv
hw/softcore_uncore.sv
testbench/tb_clk_gen.sv
testbench/softcore_uncore_assert.sv
testbench/softcore_uncore_tb.sv

//--- Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP   = softcore_uncore_tb
FLIST = flist.f
LOG   = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FLIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "all tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
